// File: logic/dfe_detector.sv
`timescale 1ns/100ps

module dfe_detector (
    input  logic                    clk,
    input  logic                    rstn,
    input  pam4_pkg::sample_beat_t  sample,
    output pam4_pkg::symbol_beat_t  decision
);

    pam4_pkg::symbol_t    prev_decision;
    pam4_pkg::residual_t  residual;
    pam4_pkg::residual_t  err [4];
    pam4_pkg::error_sq_t  err_sq [4];
    pam4_pkg::symbol_t    best_symbol;
    pam4_pkg::error_sq_t  best_err_sq;
    logic                 decision_valid;
    pam4_pkg::symbol_t    decision_symbol;

    // cancel the postcursor using our own last decision
    always_comb begin
        residual = pam4_pkg::residual_t'(sample.level)
                 - pam4_pkg::residual_t'(pam4_pkg::isi_of(prev_decision));
    end

    // error against each ideal level, then squared
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            err[i]    = residual
                      - pam4_pkg::residual_t'(pam4_pkg::level_of(pam4_pkg::symbol_t'(i)));
            err_sq[i] = err[i] * err[i];
        end
    end

    // nearest level by least squared error
    // strict compare so a tie keeps the lower symbol
    always_comb begin
        best_symbol = pam4_pkg::symbol_t'(0);
        best_err_sq = err_sq[0];
        for (int i = 1; i < 4; i++) begin
            if (err_sq[i] < best_err_sq) begin
                best_symbol = pam4_pkg::symbol_t'(i);
                best_err_sq = err_sq[i];
            end
        end
    end

    // valid strobe and feedback tap
    always_ff @(posedge clk) begin
        if (!rstn) begin
            decision_valid <= 1'b0;
            prev_decision  <= pam4_pkg::symbol_t'(1);
        end else begin
            decision_valid <= sample.valid;
            if (sample.valid) begin
                prev_decision <= best_symbol;
            end
        end
    end

    // output symbol, held between valid samples
    always_ff @(posedge clk) begin
        if (sample.valid) begin
            decision_symbol <= best_symbol;
        end
    end

    assign decision = '{valid: decision_valid, symbol: decision_symbol};

endmodule

// File: logic/isi_channel.sv
`timescale 1ns/100ps

`include "pam4_defs.svh"

module isi_channel (
    input  logic                    clk,
    input  logic                    rstn,
    input  pam4_pkg::symbol_beat_t  symbol_in,
    input  pam4_pkg::noise_t        noise_in,
    output pam4_pkg::sample_beat_t  sample
);

    // two guard bits over the sample width
    // level + isi + noise stays well inside this before the clamp
    typedef logic signed [`PAM4_SAMPLE_W+1:0] level_sum_t;

    localparam level_sum_t sat_max = level_sum_t'((1 << (`PAM4_SAMPLE_W - 1)) - 1);
    localparam level_sum_t sat_min = level_sum_t'(-(1 << (`PAM4_SAMPLE_W - 1)));

    pam4_pkg::symbol_t  prev_symbol;
    level_sum_t         level_sum;
    pam4_pkg::sample_t  level_sat;
    logic               sample_valid;
    pam4_pkg::sample_t  sample_level;

    // ideal level of the current symbol plus isi of the previous one, plus noise
    always_comb begin
        level_sum = level_sum_t'(pam4_pkg::level_of(symbol_in.symbol))
                  + level_sum_t'(pam4_pkg::isi_of(prev_symbol))
                  + level_sum_t'(noise_in);
    end

    // saturate to the sample range
    always_comb begin
        if (level_sum > sat_max) begin
            level_sat = pam4_pkg::sample_t'(sat_max);
        end else if (level_sum < sat_min) begin
            level_sat = pam4_pkg::sample_t'(sat_min);
        end else begin
            level_sat = pam4_pkg::sample_t'(level_sum);
        end
    end

    // valid strobe and channel memory
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sample_valid <= 1'b0;
            // channel starts as if the last symbol sent was 1
            prev_symbol  <= pam4_pkg::symbol_t'(1);
        end else begin
            sample_valid <= symbol_in.valid;
            if (symbol_in.valid) begin
                prev_symbol <= symbol_in.symbol;
            end
        end
    end

    // level holds through idle cycles
    always_ff @(posedge clk) begin
        if (symbol_in.valid) begin
            sample_level <= level_sat;
        end
    end

    assign sample = '{valid: sample_valid, level: sample_level};

endmodule

// File: logic/pam4_defs.svh
`ifndef PAM4_DEFS_SVH
`define PAM4_DEFS_SVH

// width of one channel sample, two's complement
`define PAM4_SAMPLE_W 8

// distance between adjacent ideal levels
// levels sit at -1.5, -0.5, +0.5 and +1.5 times this value
`define PAM4_SYMBOL_SEP 48

// one-tap isi coefficient as a right shift
// a shift of 1 gives alpha = 0.5
`define PAM4_ISI_SHIFT 1

// width of the additive noise sample, two's complement
`define PAM4_NOISE_W 6

`endif

// File: logic/pam4_link.sv
`timescale 1ns/100ps

module pam4_link (
    input  logic                    clk,
    input  logic                    rstn,
    input  pam4_pkg::symbol_beat_t  symbol_in,
    input  pam4_pkg::noise_t        noise_in,
    output pam4_pkg::sample_beat_t  sample,
    output pam4_pkg::symbol_beat_t  decision
);

    // channel output, one cycle after the symbol
    pam4_pkg::sample_beat_t channel_sample;

    // one-tap isi channel with noise
    isi_channel i_isi_channel (
        .clk       (clk),
        .rstn      (rstn),
        .symbol_in (symbol_in),
        .noise_in  (noise_in),
        .sample    (channel_sample)
    );

    // receiver, decision lands two cycles after the symbol
    dfe_detector i_dfe_detector (
        .clk      (clk),
        .rstn     (rstn),
        .sample   (channel_sample),
        .decision (decision)
    );

    // sample is also brought out for observation
    assign sample = channel_sample;

endmodule

// File: logic/pam4_pkg.sv
`include "pam4_defs.svh"

package pam4_pkg;

    // pam4 symbol, 0 is the most negative level
    typedef logic [1:0] symbol_t;

    // channel sample
    typedef logic signed [`PAM4_SAMPLE_W-1:0] sample_t;

    // additive noise sample
    typedef logic signed [`PAM4_NOISE_W-1:0] noise_t;

    // sample minus isi estimate, and slicer errors
    // two guard bits so neither step can overflow
    typedef logic signed [`PAM4_SAMPLE_W+1:0] residual_t;

    // squared slicer error, always non-negative
    typedef logic [2*(`PAM4_SAMPLE_W+2)-1:0] error_sq_t;

    typedef struct packed {
        logic    valid;
        symbol_t symbol;
    } symbol_beat_t;

    typedef struct packed {
        logic    valid;
        sample_t level;
    } sample_beat_t;

    // ideal received level of a symbol
    // (2*sym - 3) * sep / 2 gives -72, -24, 24, 72 for sep = 48
    function automatic sample_t level_of(input symbol_t sym);
        int lvl;
        lvl = ((2 * int'(sym)) - 3) * `PAM4_SYMBOL_SEP / 2;
        return sample_t'(lvl);
    endfunction

    // postcursor contribution of a symbol, alpha times its ideal level
    // arithmetic shift keeps the sign, -36, -12, 12, 36 for alpha = 0.5
    function automatic sample_t isi_of(input symbol_t sym);
        sample_t lvl;
        lvl = level_of(sym);
        return sample_t'(lvl >>> `PAM4_ISI_SHIFT);
    endfunction

endpackage

// File: sim.f
+incdir+logic
+incdir+test
logic/pam4_pkg.sv
logic/isi_channel.sv
logic/dfe_detector.sv
logic/pam4_link.sv
test/pam4_link_tb.sv

// File: test/pam4_link_model.svh
`ifndef PAM4_LINK_MODEL_SVH
`define PAM4_LINK_MODEL_SVH

`include "pam4_defs.svh"

// ideal level, -1.5, -0.5, +0.5, +1.5 times the separation
function automatic int ideal_level(input int sym);
    return sym * `PAM4_SYMBOL_SEP - (3 * `PAM4_SYMBOL_SEP) / 2;
endfunction

// alpha times the ideal level, alpha given as a right shift
function automatic int isi_level(input int sym);
    return ideal_level(sym) >>> `PAM4_ISI_SHIFT;
endfunction

// clamp to the signed sample range
function automatic int saturate(input int value);
    int hi;
    int lo;
    hi = (1 << (`PAM4_SAMPLE_W - 1)) - 1;
    lo = -(1 << (`PAM4_SAMPLE_W - 1));
    if (value > hi) begin
        return hi;
    end
    if (value < lo) begin
        return lo;
    end
    return value;
endfunction

// received sample for a symbol after the previous one, plus noise
function automatic int expected_sample(input int sym, input int prev_sym, input int noise);
    return saturate(ideal_level(sym) + isi_level(prev_sym) + noise);
endfunction

// nearest level after removing the isi of the last decision
// lowest symbol wins a tie
function automatic int expected_decision(input int level, input int prev_dec);
    int residual;
    int best_sym;
    int best_err;
    int err;
    residual = level - isi_level(prev_dec);
    best_sym = 0;
    best_err = (residual - ideal_level(0)) * (residual - ideal_level(0));
    for (int s = 1; s < 4; s++) begin
        err = (residual - ideal_level(s)) * (residual - ideal_level(s));
        if (err < best_err) begin
            best_err = err;
            best_sym = s;
        end
    end
    return best_sym;
endfunction

`endif

// File: test/pam4_link_tb.sv
`timescale 1ns/100ps

`include "pam4_defs.svh"

module pam4_link_tb;

    `include "pam4_link_model.svh"

    typedef struct packed {
        int symbol;
        int noise;
        int due;
        bit clean;
    } stim_item_t;

    typedef struct packed {
        int symbol;
        int sent;
        int due;
        bit clean;
    } dec_item_t;

    logic                    clk = 1'b0;
    logic                    rstn;
    pam4_pkg::symbol_beat_t  symbol_in;
    pam4_pkg::noise_t        noise_in;
    pam4_pkg::sample_beat_t  sample;
    pam4_pkg::symbol_beat_t  decision;

    stim_item_t  stim_q [$];
    dec_item_t   dec_q [$];
    int          mon_cycle = 0;
    int          error_count = 0;
    int          check_count = 0;
    string       test_name = "reset";

    // model state with the link's reset values
    int          model_prev_symbol = 1;
    int          model_prev_decision = 1;

    // expected outputs that must hold through idle cycles
    int          held_level = 0;
    int          held_decision = 0;
    bit          level_seen = 1'b0;
    bit          decision_seen = 1'b0;

    pam4_link i_pam4_link (
        .clk       (clk),
        .rstn      (rstn),
        .symbol_in (symbol_in),
        .noise_in  (noise_in),
        .sample    (sample),
        .decision  (decision)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string label, input integer expected, input integer actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("ERROR: %s %s expected %0d actual %0d", test_name, label, expected, actual);
        end
    endtask

    task automatic compare_outputs();
        stim_item_t         item;
        dec_item_t          ditem;
        pam4_pkg::sample_t  got_level;
        int                 exp_level;
        logic               exp_valid;
        // decisions go first since a new one is due next cycle
        exp_valid = (dec_q.size() > 0) && (dec_q[0].due == mon_cycle);
        check_value("decision valid", exp_valid, decision.valid);
        if (exp_valid) begin
            ditem = dec_q.pop_front();
            check_value("decision symbol", ditem.symbol, decision.symbol);
            if (ditem.clean) begin
                check_value("decision vs sent symbol", ditem.sent, decision.symbol);
            end
            held_decision = ditem.symbol;
            decision_seen = 1'b1;
        end else if (decision_seen) begin
            check_value("held decision symbol", held_decision, decision.symbol);
        end
        exp_valid = (stim_q.size() > 0) && (stim_q[0].due == mon_cycle);
        check_value("sample valid", exp_valid, sample.valid);
        if (exp_valid) begin
            item = stim_q.pop_front();
            got_level = sample.level;
            exp_level = expected_sample(item.symbol, model_prev_symbol, item.noise);
            model_prev_symbol = item.symbol;
            check_value("sample level", exp_level, got_level);
            held_level = exp_level;
            level_seen = 1'b1;
            ditem.symbol = expected_decision(exp_level, model_prev_decision);
            ditem.sent = item.symbol;
            ditem.clean = item.clean;
            ditem.due = mon_cycle + 1;
            model_prev_decision = ditem.symbol;
            dec_q.push_back(ditem);
        end else if (level_seen) begin
            check_value("held sample level", held_level, sample.level);
        end
    endtask

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        mon_cycle = mon_cycle + 1;
        compare_outputs();
        if (!rstn) begin
            model_prev_symbol = 1;
            model_prev_decision = 1;
            level_seen = 1'b0;
            decision_seen = 1'b0;
            stim_q.delete();
            dec_q.delete();
        end
    end

    task automatic drive_symbols(input int count, input bit noisy, input bit gaps);
        stim_item_t        item;
        pam4_pkg::noise_t  n;
        logic              v;
        int                s;
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            v = gaps ? ($urandom_range(3, 0) != 0) : 1'b1;
            s = $urandom_range(3, 0);
            if (noisy) begin
                n = pam4_pkg::noise_t'($urandom);
            end else begin
                n = '0;
            end
            symbol_in.valid  <= v;
            symbol_in.symbol <= pam4_pkg::symbol_t'(s);
            noise_in         <= n;
            if (v) begin
                item.symbol = s;
                item.noise = n;
                item.due = mon_cycle + 2;
                item.clean = !noisy;
                stim_q.push_back(item);
            end
        end
    endtask

    task automatic drive_idle(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            symbol_in.valid <= 1'b0;
            noise_in        <= '0;
        end
    endtask

    task automatic wait_for_drain(input int max_cycles);
        int waited;
        waited = 0;
        @(posedge clk);
        symbol_in.valid <= 1'b0;
        while ((stim_q.size() != 0 || dec_q.size() != 0) && waited < max_cycles) begin
            @(posedge clk);
            waited++;
        end
        if (stim_q.size() != 0 || dec_q.size() != 0) begin
            error_count++;
            $display("timeout in %s: outputs still missing after %0d cycles",
                     test_name, max_cycles);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rstn            <= 1'b0;
        symbol_in.valid <= 1'b0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;
    endtask

    initial begin
        void'($urandom(50));
        rstn = 1'b0;
        symbol_in = '0;
        noise_in = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        // both valids stay low with nothing sent
        drive_idle(8);

        test_name = "channel level";
        drive_symbols(40, 1'b0, 1'b0);
        wait_for_drain(20);

        test_name = "clean decisions";
        drive_symbols(200, 1'b0, 1'b1);
        wait_for_drain(20);

        test_name = "noise and saturation";
        drive_symbols(400, 1'b1, 1'b1);
        wait_for_drain(20);

        // registers must hold through gaps and go back to 1 on reset
        test_name = "feedback persistence";
        drive_symbols(60, 1'b1, 1'b1);
        wait_for_drain(20);
        drive_idle(5);
        apply_reset();
        drive_idle(3);
        drive_symbols(60, 1'b1, 1'b1);
        wait_for_drain(20);
        drive_idle(3);

        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
